// File: rtl/proc_config.svh
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// datapath word width
`define PROC_DATA_W 32

// architectural registers, r0 reads as zero
`define PROC_NUM_REGS 16

// program words, also sets pc width and wrap point
`define PROC_PROG_DEPTH 16

// apb byte offsets
`define PROC_ADDR_CTRL 8'h00
`define PROC_ADDR_STATUS 8'h04
`define PROC_ADDR_RESULT 8'h08
// program window, one word per 4 bytes
`define PROC_ADDR_PROG_BASE 8'h40

`endif

// File: rtl/proc_pkg.sv
`include "proc_config.svh"

package proc_pkg;

	typedef logic [`PROC_DATA_W-1:0] word_t;
	typedef logic [$clog2(`PROC_NUM_REGS)-1:0] reg_idx_t;

	// 4-bit opcode, unlisted values behave as nop
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADDI = 4'd1,
		OP_ADD = 4'd2,
		OP_SUB = 4'd3,
		OP_AND = 4'd4,
		OP_OR = 4'd5,
		OP_XOR = 4'd6,
		OP_HALT = 4'd13,
		OP_OUT = 4'd15
	} opcode_e;

	// alu function select
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_e;

	// register form: rd = ra op rb
	typedef struct packed {
		opcode_e opcode;
		reg_idx_t ra;
		reg_idx_t rb;
		reg_idx_t rd;
		logic [15:0] unused;
	} r_fmt_t;

	// immediate form: rd = ra + imm
	typedef struct packed {
		opcode_e opcode;
		reg_idx_t ra;
		logic [3:0] unused;
		reg_idx_t rd;
		logic [15:0] imm;
	} i_fmt_t;

	// same 32 bits, two views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

endpackage

// File: rtl/proc_ifs.sv
`timescale 1ns/1ps
`include "proc_config.svh"

// register file access, two reads and one write
interface regfile_if;
	proc_pkg::reg_idx_t ra_idx;
	proc_pkg::reg_idx_t rb_idx;
	proc_pkg::word_t ra_data;
	proc_pkg::word_t rb_data;
	logic wr_en;
	proc_pkg::reg_idx_t wr_idx;
	proc_pkg::word_t wr_data;

	modport core (output ra_idx, rb_idx, wr_en, wr_idx, wr_data, input ra_data, rb_data);
	modport regs (input ra_idx, rb_idx, wr_en, wr_idx, wr_data, output ra_data, rb_data);
endinterface

// program store, host port plus core fetch port
interface prog_if;
	logic host_we;
	logic [$clog2(`PROC_PROG_DEPTH)-1:0] host_addr;
	proc_pkg::word_t host_wdata;
	proc_pkg::word_t host_rdata;
	logic [$clog2(`PROC_PROG_DEPTH)-1:0] core_addr;
	proc_pkg::word_t core_rdata;

	modport host (output host_we, host_addr, host_wdata, input host_rdata);
	modport core (output core_addr, input core_rdata);
	modport mem (
		input host_we,
		input host_addr,
		input host_wdata,
		input core_addr,
		output host_rdata,
		output core_rdata
	);
endinterface

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module regfile (
	input logic clk,
	input logic arst_n,
	regfile_if.regs rf
);

	proc_pkg::word_t regs [`PROC_NUM_REGS];

	// writes land on the clock edge
	// r0 never written
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `PROC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.wr_en && (rf.wr_idx != '0)) begin
			regs[rf.wr_idx] <= rf.wr_data;
		end
	end

	// combinational reads
	// r0 forced to zero
	always_comb begin
		if (rf.ra_idx == '0) begin
			rf.ra_data = '0;
		end else begin
			rf.ra_data = regs[rf.ra_idx];
		end
	end

	always_comb begin
		if (rf.rb_idx == '0) begin
			rf.rb_data = '0;
		end else begin
			rf.rb_data = regs[rf.rb_idx];
		end
	end

	// an X write enable could corrupt any register
	a_wr_en_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(rf.wr_en));

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input proc_pkg::alu_op_e op,
	input proc_pkg::word_t a,
	input proc_pkg::word_t b,
	output proc_pkg::word_t y
);

	// purely combinational
	// add and sub wrap at word width
	always_comb begin
		case (op)
			proc_pkg::ALU_ADD: begin
				y = a + b;
			end
			proc_pkg::ALU_SUB: begin
				y = a - b;
			end
			proc_pkg::ALU_AND: begin
				y = a & b;
			end
			proc_pkg::ALU_OR: begin
				y = a | b;
			end
			proc_pkg::ALU_XOR: begin
				y = a ^ b;
			end
			// unused encodings
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

// File: rtl/prog_mem.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module prog_mem (
	input logic clk,
	prog_if.mem prog
);

	proc_pkg::word_t mem [`PROC_PROG_DEPTH];

	// host load port
	always_ff @(posedge clk) begin
		if (prog.host_we) begin
			mem[prog.host_addr] <= prog.host_wdata;
		end
	end

	// host readback
	assign prog.host_rdata = mem[prog.host_addr];

	// core fetch, same cycle as pc
	assign prog.core_rdata = mem[prog.core_addr];

	// host write must hit a real word
	a_host_addr_range: assert property (@(posedge clk)
		prog.host_we |-> !$isunknown(prog.host_addr)
			&& (int'(prog.host_addr) < `PROC_PROG_DEPTH));

endmodule

// File: rtl/proc_core.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module proc_core (
	input logic clk,
	input logic arst_n,
	input logic start,
	prog_if.core prog,
	regfile_if.core rf,
	output logic busy,
	output logic halted,
	output logic [$clog2(`PROC_PROG_DEPTH)-1:0] pc,
	output proc_pkg::word_t result,
	output logic result_valid
);

	localparam int PC_W = $clog2(`PROC_PROG_DEPTH);

	proc_pkg::instr_u instr;
	proc_pkg::alu_op_e alu_op;
	proc_pkg::word_t alu_b;
	proc_pkg::word_t alu_y;
	logic is_arith;
	logic use_imm;
	logic is_out;
	logic is_halt;
	logic [PC_W-1:0] pc_next;

	// fetch straight from program memory
	assign prog.core_addr = pc;
	assign instr = prog.core_rdata;

	// decode
	always_comb begin
		alu_op = proc_pkg::ALU_ADD;
		is_arith = 1'b0;
		use_imm = 1'b0;
		is_out = 1'b0;
		is_halt = 1'b0;
		case (instr.r_fmt.opcode)
			proc_pkg::OP_ADDI: begin
				is_arith = 1'b1;
				use_imm = 1'b1;
			end
			proc_pkg::OP_ADD: is_arith = 1'b1;
			proc_pkg::OP_SUB: begin
				alu_op = proc_pkg::ALU_SUB;
				is_arith = 1'b1;
			end
			proc_pkg::OP_AND: begin
				alu_op = proc_pkg::ALU_AND;
				is_arith = 1'b1;
			end
			proc_pkg::OP_OR: begin
				alu_op = proc_pkg::ALU_OR;
				is_arith = 1'b1;
			end
			proc_pkg::OP_XOR: begin
				alu_op = proc_pkg::ALU_XOR;
				is_arith = 1'b1;
			end
			proc_pkg::OP_HALT: is_halt = 1'b1;
			proc_pkg::OP_OUT: is_out = 1'b1;
			// nop and undefined opcodes
			default: ;
		endcase
	end

	// operand b, zero-extended imm for addi
	assign alu_b = use_imm ? proc_pkg::word_t'(instr.i_fmt.imm) : rf.rb_data;

	alu u_alu (
		.op(alu_op),
		.a(rf.ra_data),
		.b(alu_b),
		.y(alu_y)
	);

	// register reads and writeback
	assign rf.ra_idx = instr.r_fmt.ra;
	assign rf.rb_idx = instr.r_fmt.rb;
	assign rf.wr_idx = instr.i_fmt.rd;
	assign rf.wr_data = alu_y;
	assign rf.wr_en = busy && is_arith;

	// wrap at end of program memory
	assign pc_next = (pc == PC_W'(`PROC_PROG_DEPTH - 1)) ? '0 : pc + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			halted <= 1'b0;
			pc <= '0;
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			// one-cycle pulse per out
			result_valid <= 1'b0;
			if (busy) begin
				// halt leaves pc on the halt word
				if (is_halt) begin
					busy <= 1'b0;
					halted <= 1'b1;
				end else begin
					pc <= pc_next;
				end
				if (is_out) begin
					result <= rf.ra_data;
					result_valid <= 1'b1;
				end
			end else if (start) begin
				busy <= 1'b1;
				halted <= 1'b0;
				pc <= '0;
			end
		end
	end

	// halted core stays quiet until a restart
	a_no_out_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> !result_valid);

endmodule

// File: rtl/apb_host_regs.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module apb_host_regs (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input proc_pkg::word_t pwdata,
	output proc_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	prog_if.host prog,
	output logic start,
	input logic busy,
	input logic halted,
	input logic [$clog2(`PROC_PROG_DEPTH)-1:0] pc,
	input proc_pkg::word_t result
);

	localparam int PC_W = $clog2(`PROC_PROG_DEPTH);
	localparam int PROG_BYTES = 4 * `PROC_PROG_DEPTH;

	logic access;
	logic wr_access;
	logic rd_access;
	logic hit_ctrl;
	logic hit_status;
	logic hit_result;
	logic hit_prog;
	logic [7:0] prog_off;
	proc_pkg::word_t status_word;
	proc_pkg::word_t result_q;

	// no wait states, access phase always completes
	assign access = psel && penable;
	assign wr_access = access && pwrite;
	assign rd_access = access && !pwrite;
	assign pready = access;

	// address map, word aligned only
	assign hit_ctrl = (paddr == `PROC_ADDR_CTRL);
	assign hit_status = (paddr == `PROC_ADDR_STATUS);
	assign hit_result = (paddr == `PROC_ADDR_RESULT);
	assign prog_off = paddr - `PROC_ADDR_PROG_BASE;
	assign hit_prog = (paddr >= `PROC_ADDR_PROG_BASE)
		&& (int'(paddr) < int'(`PROC_ADDR_PROG_BASE) + PROG_BYTES)
		&& (paddr[1:0] == 2'b00);

	// unmapped, read-only target, or program load while running
	assign pslverr = access && (!(hit_ctrl || hit_status || hit_result || hit_prog)
		|| (pwrite && (hit_status || hit_result || (hit_prog && busy))));

	// program window
	assign prog.host_addr = prog_off[PC_W+1:2];
	assign prog.host_wdata = pwdata;
	assign prog.host_we = wr_access && hit_prog && !busy;

	// start pulse lasts the access cycle
	// ignored while running
	assign start = wr_access && hit_ctrl && pwdata[0] && !busy;

	always_comb begin
		status_word = '0;
		status_word[0] = busy;
		status_word[1] = halted;
		status_word[8 +: PC_W] = pc;
	end

	// core result only moves on out, so a plain copy holds the last value
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_q <= '0;
		end else begin
			result_q <= result;
		end
	end

	// read mux, ctrl reads as zero
	always_comb begin
		prdata = '0;
		if (rd_access) begin
			if (hit_status) begin
				prdata = status_word;
			end else if (hit_result) begin
				prdata = result_q;
			end else if (hit_prog) begin
				prdata = prog.host_rdata;
			end
		end
	end

	// access phase always follows a setup phase
	a_penable_after_psel: assert property (@(posedge clk) disable iff (!arst_n)
		penable |-> psel && $past(psel));

endmodule

// File: rtl/processor_top.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module processor_top (
	input logic clk,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input proc_pkg::word_t pwdata,
	output proc_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output proc_pkg::word_t result,
	output logic result_valid
);

	logic start;
	logic busy;
	logic halted;
	logic [$clog2(`PROC_PROG_DEPTH)-1:0] pc;

	regfile_if u_rf_if ();
	prog_if u_prog_if ();

	// host side, loads program and starts the core
	apb_host_regs u_apb_host_regs (
		.clk(clk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.prog(u_prog_if.host),
		.start(start),
		.busy(busy),
		.halted(halted),
		.pc(pc),
		.result(result)
	);

	prog_mem u_prog_mem (
		.clk(clk),
		.prog(u_prog_if.mem)
	);

	proc_core u_proc_core (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.prog(u_prog_if.core),
		.rf(u_rf_if.core),
		.busy(busy),
		.halted(halted),
		.pc(pc),
		.result(result),
		.result_valid(result_valid)
	);

	// register file beside the core
	regfile u_regfile (
		.clk(clk),
		.arst_n(arst_n),
		.rf(u_rf_if.regs)
	);

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	input logic rst_req,
	output logic clk,
	output logic arst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// low for 5 cycles at start, again on each request
	initial begin
		arst_n = 1'b0;
		forever begin
			repeat (5) @(posedge clk);
			arst_n <= 1'b1;
			do begin
				@(posedge clk);
			end while (!rst_req);
			arst_n <= 1'b0;
		end
	end

endmodule

// File: verification/processor_tb.sv
`timescale 1ns/1ps
`include "proc_config.svh"

module processor_tb;

	logic clk;
	logic arst_n;
	logic rst_req;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	proc_pkg::word_t pwdata;
	proc_pkg::word_t prdata;
	logic pready;
	logic pslverr;
	proc_pkg::word_t result;
	logic result_valid;

	// program image shared by loader and reference model
	proc_pkg::word_t prog_img [16];
	proc_pkg::word_t exp_q [$];
	proc_pkg::word_t last_out;
	logic check_on;
	int errors;
	int test_errors;
	int tests;
	int failed_tests;

	clk_gen u_clk_gen (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

	processor_top u_processor_top (
		.clk(clk),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.result(result),
		.result_valid(result_valid)
	);

	task automatic check_word(input string name, input proc_pkg::word_t got,
		input proc_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pc(input string name, input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report(input string what);
		$display("ERROR %0t %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors != test_errors) begin
			failed_tests++;
			$display("test %s: %0d error(s)", name, errors - test_errors);
		end else begin
			$display("test %s: ok", name);
		end
		test_errors = errors;
	endtask

	// instruction encoders with fields at 31:28 27:24 23:20 19:16 15:0
	function automatic proc_pkg::word_t enc_r(input logic [3:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [3:0] rd);
		return {op, ra, rb, rd, 16'h0000};
	endfunction

	function automatic proc_pkg::word_t enc_i(input logic [3:0] op, input logic [3:0] ra,
		input logic [3:0] rd, input logic [15:0] imm);
		return {op, ra, 4'h0, rd, imm};
	endfunction

	// isa model of prog_img that stops on halt or after max_outs values
	function automatic void run_program(input int max_outs, output proc_pkg::word_t outs [$],
		output logic [3:0] final_pc);
		proc_pkg::word_t regs [16];
		proc_pkg::word_t w;
		proc_pkg::word_t a;
		proc_pkg::word_t b;
		logic [3:0] pc;
		logic [3:0] op;
		logic stop;
		int steps;
		outs = {};
		pc = '0;
		stop = 1'b0;
		steps = 0;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		while (!stop && steps < 1000 && outs.size() < max_outs) begin
			w = prog_img[pc];
			op = w[31:28];
			a = regs[w[27:24]];
			// addi zero-extends imm
			b = (op == 4'd1) ? {16'h0000, w[15:0]} : regs[w[23:20]];
			final_pc = pc;
			case (op)
				4'd1, 4'd2: regs[w[19:16]] = a + b;
				4'd3: regs[w[19:16]] = a - b;
				4'd4: regs[w[19:16]] = a & b;
				4'd5: regs[w[19:16]] = a | b;
				4'd6: regs[w[19:16]] = a ^ b;
				4'd13: stop = 1'b1;
				4'd15: outs.push_back(a);
				default: ;
			endcase
			// r0 discards writes
			regs[0] = '0;
			// 4-bit pc wraps by itself
			if (!stop) begin
				pc = pc + 4'd1;
			end
			steps++;
		end
	endfunction

	// one apb transfer with setup then access until pready
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input proc_pkg::word_t wdata,
		output proc_pkg::word_t rdata, output logic err);
		int n;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			report("apb transfer never completed");
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input proc_pkg::word_t data,
		output logic err);
		proc_pkg::word_t unused;
		apb_xfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output proc_pkg::word_t data,
		output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic clear_program();
		for (int i = 0; i < 16; i++) begin
			prog_img[i] = '0;
		end
	endtask

	task automatic load_program();
		logic err;
		for (int i = 0; i < 16; i++) begin
			apb_write(`PROC_ADDR_PROG_BASE + 8'(4 * i), prog_img[i], err);
			check_flag("pslverr on load", err, 1'b0);
		end
	endtask

	task automatic pulse_reset();
		int n;
		@(posedge clk);
		rst_req <= 1'b1;
		n = 0;
		while (arst_n !== 1'b0 && n < 8) begin
			@(posedge clk);
			n++;
		end
		rst_req <= 1'b0;
		n = 0;
		while (arst_n !== 1'b1 && n < 16) begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			report("reset did not complete");
		end
	endtask

	task automatic wait_halted();
		proc_pkg::word_t st;
		logic err;
		int n;
		st = '0;
		n = 0;
		while (!st[1] && n < 64) begin
			apb_read(`PROC_ADDR_STATUS, st, err);
			n++;
		end
		if (!st[1]) begin
			report("core did not halt");
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			report("expected OUT values never arrived");
		end
	endtask

	// load, start, wait for halt, then check status and RESULT
	task automatic run_and_check();
		proc_pkg::word_t ref_q [$];
		proc_pkg::word_t st;
		logic [3:0] exp_pc;
		logic err;
		load_program();
		run_program(64, ref_q, exp_pc);
		exp_q = ref_q;
		check_on = 1'b1;
		apb_write(`PROC_ADDR_CTRL, 32'h1, err);
		wait_halted();
		wait_drained(4);
		check_on = 1'b0;
		apb_read(`PROC_ADDR_STATUS, st, err);
		check_flag("status.busy", st[0], 1'b0);
		check_flag("status.halted", st[1], 1'b1);
		check_pc("status.pc", st[11:8], exp_pc);
		if (ref_q.size() > 0) begin
			apb_read(`PROC_ADDR_RESULT, st, err);
			check_word("RESULT", st, ref_q[ref_q.size() - 1]);
		end
	endtask

	// compares each OUT pulse against the head of the expected queue
	always @(negedge clk) begin
		if (arst_n && result_valid) begin
			last_out = result;
			if (check_on) begin
				if (exp_q.size() == 0) begin
					report("OUT pulse with no value expected");
				end else begin
					check_word("result", result, exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		proc_pkg::word_t rd;
		proc_pkg::word_t words [16];
		proc_pkg::word_t ref_q [$];
		logic [3:0] ref_pc;
		logic err;
		int n;
		void'($urandom(94819));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst_req = 1'b0;
		check_on = 1'b0;
		errors = 0;
		test_errors = 0;
		tests = 0;
		failed_tests = 0;
		n = 0;
		while (arst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1) begin
			report("reset never released");
		end

		// idle outputs right after reset
		@(negedge clk);
		check_flag("pready", pready, 1'b0);
		check_flag("pslverr", pslverr, 1'b0);
		check_flag("result_valid", result_valid, 1'b0);

		// status after reset then program window readback
		apb_read(`PROC_ADDR_STATUS, rd, err);
		check_word("STATUS", rd, '0);
		for (int i = 0; i < 16; i++) begin
			words[i] = $urandom();
			apb_write(`PROC_ADDR_PROG_BASE + 8'(4 * i), words[i], err);
		end
		for (int i = 0; i < 16; i++) begin
			apb_read(`PROC_ADDR_PROG_BASE + 8'(4 * i), rd, err);
			check_word("prog readback", rd, words[i]);
		end
		finish_test("program readback");

		// add sub and or xor on two loaded values with one out each
		clear_program();
		prog_img[0] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd1, 16'h1234);
		prog_img[1] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd2, 16'h0f0f);
		for (int k = 0; k < 5; k++) begin
			prog_img[2 + 2 * k] = enc_r(4'(2 + k), 4'd2, 4'd1, 4'(3 + k));
			prog_img[3 + 2 * k] = enc_r(proc_pkg::OP_OUT, 4'(3 + k), 4'd0, 4'd0);
		end
		prog_img[12] = enc_r(proc_pkg::OP_HALT, 4'd0, 4'd0, 4'd0);
		run_and_check();
		finish_test("fixed arithmetic");

		clear_program();
		prog_img[0] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd0, 16'h0055);
		prog_img[1] = enc_r(proc_pkg::OP_OUT, 4'd0, 4'd0, 4'd0);
		prog_img[2] = enc_r(proc_pkg::OP_HALT, 4'd0, 4'd0, 4'd0);
		run_and_check();
		check_word("r0 out", last_out, '0);
		finish_test("r0 stays zero");

		// r1..r4 loaded first then random ops and a final out before halt
		for (int p = 0; p < 5; p++) begin
			clear_program();
			for (int i = 0; i < 4; i++) begin
				prog_img[i] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'(i + 1), 16'($urandom()));
			end
			for (int i = 4; i < 14; i++) begin
				n = $urandom_range(0, 6);
				if (n < 5) begin
					prog_img[i] = enc_r(4'(n + 2), 4'($urandom_range(1, 4)),
						4'($urandom_range(1, 4)), 4'($urandom_range(1, 4)));
				end else if (n == 5) begin
					prog_img[i] = enc_i(proc_pkg::OP_ADDI, 4'($urandom_range(1, 4)),
						4'($urandom_range(1, 4)), 16'($urandom()));
				end else begin
					prog_img[i] = enc_r(proc_pkg::OP_OUT, 4'($urandom_range(1, 4)), 4'd0, 4'd0);
				end
			end
			prog_img[14] = enc_r(proc_pkg::OP_OUT, 4'($urandom_range(1, 4)), 4'd0, 4'd0);
			prog_img[15] = enc_r(proc_pkg::OP_HALT, 4'd0, 4'd0, 4'd0);
			run_and_check();
		end
		finish_test("random programs");

		// no halt and outs at words 5 and 15 so pc wraps
		clear_program();
		prog_img[0] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd1, 16'h0011);
		prog_img[1] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd2, 16'h0022);
		prog_img[2] = enc_r(proc_pkg::OP_ADD, 4'd1, 4'd2, 4'd3);
		prog_img[5] = enc_r(proc_pkg::OP_OUT, 4'd3, 4'd0, 4'd0);
		prog_img[15] = enc_r(proc_pkg::OP_OUT, 4'd1, 4'd0, 4'd0);
		load_program();
		run_program(20, ref_q, ref_pc);
		exp_q = ref_q;
		check_on = 1'b1;
		apb_write(`PROC_ADDR_CTRL, 32'h1, err);
		wait_drained(400);
		check_on = 1'b0;
		apb_read(`PROC_ADDR_STATUS, rd, err);
		check_flag("status.busy", rd[0], 1'b1);
		// ctrl write while running is accepted but ignored
		apb_write(`PROC_ADDR_CTRL, 32'h1, err);
		check_flag("pslverr ctrl busy", err, 1'b0);
		pulse_reset();
		// program memory survives reset and restart begins at word 0
		exp_q = {};
		for (int i = 0; i < 4; i++) begin
			exp_q.push_back(ref_q[i]);
		end
		check_on = 1'b1;
		apb_write(`PROC_ADDR_CTRL, 32'h1, err);
		wait_drained(100);
		check_on = 1'b0;
		pulse_reset();
		finish_test("wrap and restart");

		apb_read(8'h20, rd, err);
		check_flag("pslverr unmapped", err, 1'b1);
		apb_write(`PROC_ADDR_STATUS, 32'h3, err);
		check_flag("pslverr status write", err, 1'b1);
		// 16 cycle run leaves time for a load while busy
		clear_program();
		prog_img[3] = enc_i(proc_pkg::OP_ADDI, 4'd0, 4'd1, 16'h0077);
		prog_img[15] = enc_r(proc_pkg::OP_HALT, 4'd0, 4'd0, 4'd0);
		load_program();
		apb_write(`PROC_ADDR_CTRL, 32'h1, err);
		apb_write(`PROC_ADDR_PROG_BASE + 8'd12, 32'ha5a5_a5a5, err);
		check_flag("pslverr busy load", err, 1'b1);
		wait_halted();
		apb_read(`PROC_ADDR_PROG_BASE + 8'd12, rd, err);
		check_word("prog word 3", rd, prog_img[3]);
		finish_test("apb errors");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: processor_top.f
+incdir+rtl
rtl/proc_pkg.sv
rtl/proc_ifs.sv
rtl/regfile.sv
rtl/alu.sv
rtl/prog_mem.sv
rtl/proc_core.sv
rtl/apb_host_regs.sv
rtl/processor_top.sv
verification/clk_gen.sv
verification/processor_tb.sv

// File: Bender.yml
package:
  name: processor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/proc_pkg.sv
      - rtl/proc_ifs.sv
      - rtl/regfile.sv
      - rtl/alu.sv
      - rtl/prog_mem.sv
      - rtl/proc_core.sv
      - rtl/apb_host_regs.sv
      - rtl/processor_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/clk_gen.sv
      - verification/processor_tb.sv
